// ==== hw/spi_proto_pkg.sv ====
package spi_proto_pkg;

    // ---------------------------------------------------------------------
    // Frame state of the slave
    // ---------------------------------------------------------------------

    // Idle waits for chip select
    // Load takes the next transmit byte for one cycle
    // Shift follows SCLK until the byte is complete
    // Done hands the received byte to the host for one cycle
    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_LOAD  = 2'b01,
        ST_SHIFT = 2'b10,
        ST_DONE  = 2'b11
    } slave_state_t;

    // ---------------------------------------------------------------------
    // Master lines after resynchronization
    // ---------------------------------------------------------------------

    // Levels and pulses are aligned, pulses last one system cycle
    typedef struct packed {
        logic       ss_n;       // chip select level, low inside a frame
        logic       ss_fall;    // frame start
        logic       ss_rise;    // frame end or abort
        logic       sclk_rise;  // MISO advances here
        logic       sclk_fall;  // MOSI is sampled here
        logic       mosi;       // data level from the master
        logic [1:0] spare;
    } spi_lines_t;

endpackage

// ==== hw/spi_host_pkg.sv ====
package spi_host_pkg;

    // Widest SPI word the host structs can carry
    localparam int DATA_WIDTH_MAX = 8;

    // ---------------------------------------------------------------------
    // Receive port towards the host
    // ---------------------------------------------------------------------

    // Data is stable for as long as req is high
    typedef struct packed {
        logic                      req;
        logic [DATA_WIDTH_MAX-1:0] data;
    } rx_port_t;

    // ---------------------------------------------------------------------
    // Transmit buffer and status
    // ---------------------------------------------------------------------

    // One byte written by the host and not yet sent
    typedef struct packed {
        logic                      valid;
        logic [DATA_WIDTH_MAX-1:0] data;
    } tx_pend_t;

    // Sticky error flags, cleared only by reset
    typedef struct packed {
        logic overrun;   // byte dropped, receive handshake still open
        logic underrun;  // all-ones sent, no transmit byte waiting
    } status_t;

endpackage

// ==== hw/spi_cdc_sync.sv ====
`timescale 1ns/1ps

module spi_cdc_sync #(
    parameter int   SYNC_STAGES = 2,
    parameter logic RESET_LEVEL = 1'b0
) (
    input  logic SClk_fallingedge,
    input  logic reset_i,
    input  logic async_i,
    output logic sync_o,
    output logic rise_o,
    output logic fall_o
);

    // Metastability chain, newest sample in bit 0
    logic [SYNC_STAGES-1:0] chain_q;
    // Settled level, one cycle behind the chain end
    logic                   level_q;

    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            // Idle level of the line, so no edge is seen after reset
            chain_q <= {SYNC_STAGES{RESET_LEVEL}};
            level_q <= RESET_LEVEL;
            rise_o  <= 1'b0;
            fall_o  <= 1'b0;
        end else begin
            chain_q <= {chain_q[SYNC_STAGES-2:0], async_i};
            level_q <= chain_q[SYNC_STAGES-1];
            // Compare chain end with the settled level
            rise_o  <= chain_q[SYNC_STAGES-1] & ~level_q;
            fall_o  <= ~chain_q[SYNC_STAGES-1] & level_q;
        end
    end

    // Level changes in the same cycle as its edge pulse
    assign sync_o = level_q;

endmodule

// ==== hw/spi_slave_fsm.sv ====
`timescale 1ns/1ps

module spi_slave_fsm (
    input  logic                      SClk_fallingedge,
    input  logic                      reset_i,
    input  spi_proto_pkg::spi_lines_t lines_i,
    input  logic                      last_i,
    output logic                      load_o,
    output logic                      count_clear_o,
    output logic                      count_step_o,
    output logic                      byte_done_o
);

    spi_proto_pkg::slave_state_t state_q;
    spi_proto_pkg::slave_state_t state_d;

    // ---------------------------------------------------------------------
    // Next state
    // ---------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            spi_proto_pkg::ST_IDLE: begin
                // Frame start from the master
                if (lines_i.ss_fall) begin
                    state_d = spi_proto_pkg::ST_LOAD;
                end
            end
            spi_proto_pkg::ST_LOAD: begin
                // Single cycle, transmit byte taken
                state_d = spi_proto_pkg::ST_SHIFT;
            end
            spi_proto_pkg::ST_SHIFT: begin
                // Last sampling edge of the byte
                if (lines_i.sclk_fall && last_i) begin
                    state_d = spi_proto_pkg::ST_DONE;
                end
            end
            spi_proto_pkg::ST_DONE: begin
                // Another byte follows while chip select stays low
                if (lines_i.ss_n) begin
                    state_d = spi_proto_pkg::ST_IDLE;
                end else begin
                    state_d = spi_proto_pkg::ST_LOAD;
                end
            end
            default: begin
                state_d = spi_proto_pkg::ST_IDLE;
            end
        endcase
        // Chip select released, partial byte is dropped
        if (lines_i.ss_rise) begin
            state_d = spi_proto_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            state_q <= spi_proto_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ---------------------------------------------------------------------
    // Strobes
    // ---------------------------------------------------------------------
    assign load_o        = (state_q == spi_proto_pkg::ST_LOAD);
    assign byte_done_o   = (state_q == spi_proto_pkg::ST_DONE);
    // Only sampling edges inside a byte are counted
    assign count_step_o  = lines_i.sclk_fall && (state_q == spi_proto_pkg::ST_SHIFT);
    // Counter starts from zero for every frame
    assign count_clear_o = lines_i.ss_rise || (state_q == spi_proto_pkg::ST_IDLE);

    // Loading the next byte never overlaps the hand-off of the previous one
    a_load_vs_done: assert property (@(posedge SClk_fallingedge) disable iff (!reset_i)
        !(load_o && byte_done_o));

endmodule

// ==== hw/spi_bit_counter.sv ====
`timescale 1ns/1ps

module spi_bit_counter #(
    parameter int DATA_WIDTH = 8
) (
    input  logic SClk_fallingedge,
    input  logic reset_i,
    input  logic clear_i,
    input  logic step_i,
    output logic last_o
);

    localparam int               CNT_W    = $clog2(DATA_WIDTH);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DATA_WIDTH - 1);

    // Bits sampled so far in the current byte
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (step_i) begin
            // Wrap at the byte boundary
            if (last_o) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // High while the next sampling edge completes the byte
    assign last_o = (cnt_q == CNT_LAST);

    // Non power of two widths must still wrap at DATA_WIDTH-1
    a_cnt_range: assert property (@(posedge SClk_fallingedge) disable iff (!reset_i)
        cnt_q <= CNT_LAST);

endmodule

// ==== hw/spi_shift_unit.sv ====
`timescale 1ns/1ps

module spi_shift_unit #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                      SClk_fallingedge,
    input  logic                      reset_i,
    input  spi_proto_pkg::spi_lines_t lines_i,
    input  logic                      load_i,
    input  logic                      shift_en_i,
    input  logic [DATA_WIDTH-1:0]     tx_word_i,
    output logic [DATA_WIDTH-1:0]     rx_word_o,
    output logic                      miso_o
);

    logic [DATA_WIDTH-1:0] rx_q;
    logic [DATA_WIDTH-1:0] tx_q;
    // Set by the first sampling edge of a byte
    logic                  tx_armed_q;

    // ---------------------------------------------------------------------
    // Receive shift register
    // ---------------------------------------------------------------------

    // MSB first, new bit enters at the LSB side
    always_ff @(posedge SClk_fallingedge) begin
        if (shift_en_i && lines_i.sclk_fall) begin
            rx_q <= {rx_q[DATA_WIDTH-2:0], lines_i.mosi};
        end
    end

    // ---------------------------------------------------------------------
    // Transmit shift register
    // ---------------------------------------------------------------------
    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            tx_q       <= '0;
            tx_armed_q <= 1'b0;
        end else if (load_i) begin
            // MSB goes to MISO before the first SCLK edge of the byte
            tx_q       <= tx_word_i;
            tx_armed_q <= 1'b0;
        end else if (shift_en_i) begin
            // First rising edge of a byte keeps the MSB, the master
            // has not sampled it yet
            if (lines_i.sclk_rise && tx_armed_q) begin
                tx_q <= {tx_q[DATA_WIDTH-2:0], 1'b0};
            end
            if (lines_i.sclk_fall) begin
                tx_armed_q <= 1'b1;
            end
        end
    end

    // Valid at byte_done, the last bit entered the cycle before
    assign rx_word_o = rx_q;
    assign miso_o    = tx_q[DATA_WIDTH-1];

endmodule

// ==== hw/spi_host_port.sv ====
`timescale 1ns/1ps

module spi_host_port #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                   SClk_fallingedge,
    input  logic                   reset_i,
    input  logic                   byte_done_i,
    input  logic [DATA_WIDTH-1:0]  rx_word_i,
    input  logic                   load_i,
    output logic [DATA_WIDTH-1:0]  tx_word_o,
    output spi_host_pkg::rx_port_t rx_o,
    input  logic                   rx_ack_i,
    input  logic                   tx_req_i,
    input  logic [DATA_WIDTH-1:0]  tx_data_i,
    output logic                   tx_ack_o,
    output spi_host_pkg::status_t  status_o
);

    spi_host_pkg::rx_port_t rx_q;
    // Byte latched, req follows next cycle
    logic                   rx_take_q;
    spi_host_pkg::tx_pend_t pend_q;
    spi_host_pkg::status_t  status_q;
    // Handshake still open, a new byte cannot be taken
    logic                   rx_busy;

    assign rx_busy = rx_q.req | rx_ack_i | rx_take_q;

    // ---------------------------------------------------------------------
    // Receive handshake, four-phase
    // ---------------------------------------------------------------------
    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            rx_q.req  <= 1'b0;
            rx_take_q <= 1'b0;
        end else begin
            rx_take_q <= 1'b0;
            if (byte_done_i && !rx_busy) begin
                rx_q.data <= rx_word_i;
                rx_take_q <= 1'b1;
            end
            // Raise after the latch, drop on ack
            if (rx_take_q) begin
                rx_q.req <= 1'b1;
            end else if (rx_ack_i) begin
                rx_q.req <= 1'b0;
            end
        end
    end

    assign rx_o = rx_q;

    // ---------------------------------------------------------------------
    // Transmit handshake and pending byte
    // ---------------------------------------------------------------------
    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            pend_q.valid <= 1'b0;
            tx_ack_o     <= 1'b0;
        end else if (tx_req_i && !tx_ack_o) begin
            // New byte wins over a load in the same cycle
            pend_q.data  <= tx_data_i;
            pend_q.valid <= 1'b1;
            tx_ack_o     <= 1'b1;
        end else begin
            if (!tx_req_i) begin
                tx_ack_o <= 1'b0;
            end
            // Byte consumed by the shift unit
            if (load_i) begin
                pend_q.valid <= 1'b0;
            end
        end
    end

    // Fill value when the host fell behind
    assign tx_word_o = pend_q.valid ? pend_q.data : '1;

    // ---------------------------------------------------------------------
    // Sticky status
    // ---------------------------------------------------------------------
    always_ff @(posedge SClk_fallingedge) begin
        if (!reset_i) begin
            status_q <= '0;
        end else begin
            if (byte_done_i && rx_busy) begin
                status_q.overrun <= 1'b1;
            end
            if (load_i && !pend_q.valid) begin
                status_q.underrun <= 1'b1;
            end
        end
    end

    assign status_o = status_q;

    // Req is only withdrawn in answer to the host
    a_rx_req_hold: assert property (@(posedge SClk_fallingedge) disable iff (!reset_i)
        $fell(rx_q.req) |-> $past(rx_ack_i));

endmodule

// ==== hw/spi_slave_top.sv ====
`timescale 1ns/1ps

module spi_slave_top #(
    parameter int DATA_WIDTH  = 8,
    parameter int SYNC_STAGES = 2
) (
    input  logic                   SClk_fallingedge,
    input  logic                   reset_i,
    input  logic                   sclk_i,
    input  logic                   mosi_i,
    input  logic                   ss_n_i,
    output logic                   miso_o,
    output spi_host_pkg::rx_port_t rx_o,
    input  logic                   rx_ack_i,
    input  logic                   tx_req_i,
    input  logic [DATA_WIDTH-1:0]  tx_data_i,
    output logic                   tx_ack_o,
    output spi_host_pkg::status_t  status_o
);

    logic                      ss_n_sync;
    logic                      ss_fall;
    logic                      ss_rise;
    logic                      sclk_rise;
    logic                      sclk_fall;
    logic                      mosi_sync;
    spi_proto_pkg::spi_lines_t lines;
    logic                      frame_active;
    logic                      last;
    logic                      load;
    logic                      count_clear;
    logic                      count_step;
    logic                      byte_done;
    logic [DATA_WIDTH-1:0]     rx_word;
    logic [DATA_WIDTH-1:0]     tx_word;

    // Host structs are sized for exactly this width
    if (DATA_WIDTH != spi_host_pkg::DATA_WIDTH_MAX) begin : g_width_check
        $error("DATA_WIDTH must equal spi_host_pkg::DATA_WIDTH_MAX");
    end
    if (SYNC_STAGES < 2) begin : g_sync_check
        $error("SYNC_STAGES must be at least 2");
    end

    // ---------------------------------------------------------------------
    // Master lines into the system clock domain
    // ---------------------------------------------------------------------

    // Chip select idles high
    spi_cdc_sync #(.SYNC_STAGES(SYNC_STAGES), .RESET_LEVEL(1'b1)) i_sync_ss (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i), .async_i(ss_n_i),
        .sync_o(ss_n_sync), .rise_o(ss_rise), .fall_o(ss_fall)
    );

    // Only the edges of SCLK matter
    spi_cdc_sync #(.SYNC_STAGES(SYNC_STAGES), .RESET_LEVEL(1'b0)) i_sync_sclk (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i), .async_i(sclk_i),
        .sync_o(), .rise_o(sclk_rise), .fall_o(sclk_fall)
    );

    // Only the level of MOSI matters
    spi_cdc_sync #(.SYNC_STAGES(SYNC_STAGES), .RESET_LEVEL(1'b0)) i_sync_mosi (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i), .async_i(mosi_i),
        .sync_o(mosi_sync), .rise_o(), .fall_o()
    );

    assign lines = '{ss_n: ss_n_sync, ss_fall: ss_fall, ss_rise: ss_rise,
                     sclk_rise: sclk_rise, sclk_fall: sclk_fall, mosi: mosi_sync,
                     spare: 2'b00};
    assign frame_active = ~lines.ss_n;

    // ---------------------------------------------------------------------
    // Frame control and data path
    // ---------------------------------------------------------------------
    spi_slave_fsm i_fsm (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i), .lines_i(lines),
        .last_i(last), .load_o(load), .count_clear_o(count_clear),
        .count_step_o(count_step), .byte_done_o(byte_done)
    );

    spi_bit_counter #(.DATA_WIDTH(DATA_WIDTH)) i_counter (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i),
        .clear_i(count_clear), .step_i(count_step), .last_o(last)
    );

    spi_shift_unit #(.DATA_WIDTH(DATA_WIDTH)) i_shift (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i), .lines_i(lines),
        .load_i(load), .shift_en_i(frame_active), .tx_word_i(tx_word),
        .rx_word_o(rx_word), .miso_o(miso_o)
    );

    spi_host_port #(.DATA_WIDTH(DATA_WIDTH)) i_host (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i),
        .byte_done_i(byte_done), .rx_word_i(rx_word), .load_i(load),
        .tx_word_o(tx_word), .rx_o(rx_o), .rx_ack_i(rx_ack_i),
        .tx_req_i(tx_req_i), .tx_data_i(tx_data_i), .tx_ack_o(tx_ack_o),
        .status_o(status_o)
    );

    // Byte offered by the host port at load is on MISO one cycle later
    a_load_to_miso: assert property (@(posedge SClk_fallingedge) disable iff (!reset_i)
        (i_fsm.state_q == spi_proto_pkg::ST_LOAD) |=> (miso_o == $past(tx_word[DATA_WIDTH-1])));

endmodule

// ==== bench/spi_master_bfm.sv ====
`timescale 1ns/1ps

module spi_master_bfm (
    input  logic SClk_fallingedge,
    input  logic miso_i,
    output logic sclk_o,
    output logic mosi_o,
    output logic ss_n_o,
    output int   bytes_started_o
);

    // Bus idle, chip select released, SCLK low as mode 0 requires
    initial begin
        sclk_o          = 1'b0;
        mosi_o          = 1'b0;
        ss_n_o          = 1'b1;
        bytes_started_o <= 0;
    end

    // n rising edges, then 5 ns past the last one
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge SClk_fallingedge);
        #5;
    endtask

    // ---------------------------------------------------------------------
    // One frame
    // ---------------------------------------------------------------------

    // Byte k sits at bits [8k+7:8k], sent MSB first
    // abort_bits above zero ends the frame after that many bits
    task automatic run_frame(input logic [63:0] tx_bits, input int n_bytes,
                             input int abort_bits, output logic [63:0] rx_bits);
        int half;
        int total;
        int n;
        int pos;
        // Half period of 4 to 6 system cycles
        half    = 4 + ($urandom % 3);
        total   = (abort_bits > 0) ? abort_bits : 8 * n_bytes;
        rx_bits = '0;
        wait_cycles(1);
        ss_n_o = 1'b0;
        wait_cycles(half);
        for (n = 0; n < total; n++) begin
            pos = 8 * (n / 8) + 7 - (n % 8);
            // MOSI moves with the rising edge
            sclk_o = 1'b1;
            mosi_o = tx_bits[pos];
            wait_cycles(half);
            // Slave samples MOSI here, MISO is taken at the same edge
            sclk_o       = 1'b0;
            rx_bits[pos] = miso_i;
            if (n % 8 == 0) begin
                bytes_started_o <= bytes_started_o + 1;
            end
            wait_cycles(half);
        end
        ss_n_o = 1'b1;
        mosi_o = 1'b0;
        // Gap so the next frame start is a fresh edge
        wait_cycles(2 * half);
    endtask

endmodule

// ==== bench/spi_slave_tb.sv ====
`timescale 1ns/1ps

module spi_slave_tb;

    localparam int TIMEOUT = 2000;

    logic                   SClk_fallingedge;
    logic                   reset_i;
    logic                   sclk;
    logic                   mosi;
    logic                   ss_n;
    logic                   miso;
    spi_host_pkg::rx_port_t rx_port;
    logic                   rx_ack;
    logic                   tx_req;
    logic [7:0]             tx_data;
    logic                   tx_ack;
    spi_host_pkg::status_t  status;
    int                     started;

    int         errors;
    int         timeouts;
    // Host withholds rx ack while set
    logic       hold_ack;
    int         ack_delay;
    logic [7:0] rx_got[$];
    // Reference model state
    logic [7:0] rx_exp[$];
    logic       exp_overrun;
    logic       exp_underrun;

    initial SClk_fallingedge = 1'b0;
    always #50 SClk_fallingedge = ~SClk_fallingedge;

    spi_slave_top #(.DATA_WIDTH(8), .SYNC_STAGES(2)) i_spi_slave_top (
        .SClk_fallingedge(SClk_fallingedge), .reset_i(reset_i), .sclk_i(sclk),
        .mosi_i(mosi), .ss_n_i(ss_n), .miso_o(miso), .rx_o(rx_port), .rx_ack_i(rx_ack),
        .tx_req_i(tx_req), .tx_data_i(tx_data), .tx_ack_o(tx_ack), .status_o(status)
    );

    spi_master_bfm i_master (
        .SClk_fallingedge(SClk_fallingedge), .miso_i(miso), .sclk_o(sclk),
        .mosi_o(mosi), .ss_n_o(ss_n), .bytes_started_o(started)
    );

    // ---------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------
    task automatic step(input int n);
        repeat (n) @(posedge SClk_fallingedge);
        #5;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    endtask

    task automatic apply_reset();
        reset_i = 1'b0;
        step(8);
        reset_i      = 1'b1;
        exp_overrun  = 1'b0;
        exp_underrun = 1'b0;
        rx_got.delete();
        rx_exp.delete();
        step(2);
    endtask

    // ---------------------------------------------------------------------
    // Host side
    // ---------------------------------------------------------------------

    // Four-phase write with ack one cycle after each req edge
    task automatic write_tx(input logic [7:0] data);
        int waited;
        tx_data = data;
        tx_req  = 1'b1;
        waited  = 0;
        while (!tx_ack && waited < TIMEOUT) begin
            step(1);
            waited++;
        end
        if (!tx_ack) begin
            timed_out("tx_ack_o to rise");
        end else begin
            check_value("tx ack rise latency", 1, waited);
        end
        tx_req = 1'b0;
        waited = 0;
        while (tx_ack && waited < TIMEOUT) begin
            step(1);
            waited++;
        end
        if (tx_ack) begin
            timed_out("tx_ack_o to fall");
        end else begin
            check_value("tx ack fall latency", 1, waited);
        end
    endtask

    // Byte k is written once byte k-1 is on the wire
    task automatic feed_tx(input logic [63:0] tx_bits, input int n_writes, input int base);
        int k;
        int waited;
        for (k = 1; k < n_writes; k++) begin
            waited = 0;
            while (started < base + k && waited < TIMEOUT) begin
                step(1);
                waited++;
            end
            if (started < base + k) begin
                timed_out("the master to start a byte");
            end else begin
                write_tx(tx_bits[8*k +: 8]);
            end
        end
    endtask

    // Receive handshake with data checked stable until ack
    initial begin : host_rx
        logic [7:0] held;
        int         phase;
        int         wait_left;
        int         waited;
        phase = 0;
        forever begin
            step(1);
            case (phase)
                0: begin
                    if (rx_port.req && !hold_ack) begin
                        held      = rx_port.data;
                        wait_left = ack_delay;
                        phase     = 1;
                    end
                end
                1: begin
                    check_value("rx req held", 1, rx_port.req);
                    check_value("rx data stable", held, rx_port.data);
                    if (wait_left == 0) begin
                        rx_ack = 1'b1;
                        rx_got.push_back(held);
                        waited = 0;
                        phase  = 2;
                    end else begin
                        wait_left--;
                    end
                end
                default: begin
                    if (!rx_port.req) begin
                        rx_ack = 1'b0;
                        phase  = 0;
                    end else begin
                        waited++;
                        if (waited >= TIMEOUT) begin
                            timed_out("rx req to drop after ack");
                            rx_ack = 1'b0;
                            phase  = 0;
                        end
                    end
                end
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // Frame with model prediction
    // ---------------------------------------------------------------------
    task automatic run_case(input string name, input int n_bytes, input int abort_bits,
                            input int n_writes);
        logic [63:0] mosi_bits;
        logic [63:0] tx_bits;
        logic [63:0] miso_bits;
        logic [7:0]  exp_miso;
        int          loads;
        int          base;
        int          k;
        mosi_bits = {$urandom, $urandom};
        tx_bits   = {$urandom, $urandom};
        ack_delay = $urandom % 12;
        if (n_writes > 0) begin
            write_tx(tx_bits[7:0]);
        end
        base = started;
        fork
            i_master.run_frame(mosi_bits, n_bytes, abort_bits, miso_bits);
            feed_tx(tx_bits, n_writes, base);
        join
        // Chip select is still low after each byte so a full frame ends with one extra load
        loads = (abort_bits > 0) ? 1 : n_bytes + 1;
        if (n_writes < loads) begin
            exp_underrun = 1'b1;
        end
        for (k = 0; k < n_bytes && abort_bits == 0; k++) begin
            exp_miso = (k < n_writes) ? tx_bits[8*k +: 8] : 8'hff;
            check_value({name, " miso"}, exp_miso, miso_bits[8*k +: 8]);
            // Open handshake drops every later byte
            if (!hold_ack || k == 0) begin
                rx_exp.push_back(mosi_bits[8*k +: 8]);
            end else begin
                exp_overrun = 1'b1;
            end
        end
    endtask

    task automatic expect_rx(input string name);
        int waited;
        int k;
        waited = 0;
        while (rx_got.size() < rx_exp.size() && waited < TIMEOUT) begin
            step(1);
            waited++;
        end
        if (rx_got.size() < rx_exp.size()) begin
            timed_out("the rx req/ack handshake");
        end
        // Room for a stray byte to show up
        step(12);
        check_value({name, " rx count"}, rx_exp.size(), rx_got.size());
        for (k = 0; k < rx_exp.size() && k < rx_got.size(); k++) begin
            check_value({name, " rx byte"}, rx_exp[k], rx_got[k]);
        end
        check_value({name, " overrun"}, exp_overrun, status.overrun);
        check_value({name, " underrun"}, exp_underrun, status.underrun);
        rx_got.delete();
        rx_exp.delete();
    endtask

    // ---------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------
    initial begin : main
        int n;
        errors       = 0;
        timeouts     = 0;
        reset_i      = 1'b0;
        rx_ack       = 1'b0;
        tx_req       = 1'b0;
        tx_data      = 8'h00;
        hold_ack     = 1'b0;
        ack_delay    = 0;
        exp_overrun  = 1'b0;
        exp_underrun = 1'b0;
        void'($urandom(32'h31d3));

        apply_reset();
        run_case("single byte", 1, 0, 0);
        expect_rx("single byte");

        apply_reset();
        run_case("tx byte", 1, 0, 2);
        expect_rx("tx byte");

        apply_reset();
        n = 2 + $urandom % 4;
        run_case("multi byte", n, 0, n + 1);
        expect_rx("multi byte");

        apply_reset();
        run_case("tx underrun", 2, 0, 1);
        expect_rx("tx underrun");

        // First byte must wait on rx_o while the second is lost
        apply_reset();
        hold_ack = 1'b1;
        run_case("overrun", 2, 0, 3);
        check_value("overrun req held", 1, rx_port.req);
        check_value("overrun data held", rx_exp[0], rx_port.data);
        hold_ack = 1'b0;
        expect_rx("overrun");

        apply_reset();
        run_case("abort", 0, 3 + $urandom % 4, 0);
        check_value("abort no req", 0, rx_port.req);
        expect_rx("abort");
        run_case("after abort", 1, 0, 2);
        expect_rx("after abort");

        finish_run();
    end

endmodule

// ==== compile.f ====
hw/spi_proto_pkg.sv
hw/spi_host_pkg.sv
hw/spi_cdc_sync.sv
hw/spi_slave_fsm.sv
hw/spi_bit_counter.sv
hw/spi_shift_unit.sv
hw/spi_host_port.sv
hw/spi_slave_top.sv
bench/spi_master_bfm.sv
bench/spi_slave_tb.sv

// ==== Bender.yml ====
package:
  name: spi_slave

sources:
  # Packages
  - hw/spi_proto_pkg.sv
  - hw/spi_host_pkg.sv
  # RTL
  - hw/spi_cdc_sync.sv
  - hw/spi_slave_fsm.sv
  - hw/spi_bit_counter.sv
  - hw/spi_shift_unit.sv
  - hw/spi_host_port.sv
  - hw/spi_slave_top.sv
  # Testbench
  - target: test
    files:
      - bench/spi_master_bfm.sv
      - bench/spi_slave_tb.sv
